//--- apb_sequencer.sv
`timescale 1ns/10ps
`include "axil2apb_consts.svh"

// APB master phase sequencer
// Setup cycle after a start, then access cycles until PREADY
module apb_sequencer
(
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,

	// Start strobes from the arbiter
	input logic i_wr_start,
	input logic i_rd_start,

	// Request payloads from the skid buffers
	input axil2apb_pkg::axil_addr_t i_aw,
	input axil2apb_pkg::axil_addr_t i_ar,
	input axil2apb_pkg::axil_wdata_t i_w,

	// APB request side
	output logic o_psel,
	output logic o_penable,
	output logic [`AXI_ADDR_W-1:0] o_paddr,
	output logic o_pwrite,
	output logic [`AXI_DATA_W-1:0] o_pwdata,
	output logic [`AXI_STRB_W-1:0] o_pwstrb,
	output logic [`AXI_PROT_W-1:0] o_pprot,

	// APB completion side
	input logic i_pready,
	input logic [`AXI_DATA_W-1:0] i_prdata,
	input logic i_pslverr,

	// Completion report
	output logic o_done,
	output logic o_done_write,
	output axil2apb_pkg::apb_rsp_t o_rsp
);

	//////////////////////////////////////////////////
	// Phase control
	//////////////////////////////////////////////////

	// Idle to setup on a start
	// Setup to access unconditionally
	// Access back to idle on PREADY
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			o_psel <= 1'b0;
			o_penable <= 1'b0;
		end
		else if (!o_psel)
		begin
			o_psel <= i_wr_start || i_rd_start;
		end
		else if (!o_penable)
		begin
			o_penable <= 1'b1;
		end
		else if (i_pready)
		begin
			o_psel <= 1'b0;
			o_penable <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// Request capture
	//////////////////////////////////////////////////

	// Fields held for the whole transfer
	// Byte address rebuilt with zero lane bits
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_rd_start)
		begin
			o_paddr <= {i_ar.addr, {`AXI_LSB{1'b0}}};
			o_pwrite <= 1'b0;
			o_pprot <= i_ar.prot;
		end
		else if (i_wr_start)
		begin
			o_paddr <= {i_aw.addr, {`AXI_LSB{1'b0}}};
			o_pwrite <= 1'b1;
			o_pprot <= i_aw.prot;
			o_pwdata <= i_w.data;
			o_pwstrb <= i_w.strb;
		end
	end

	// Completing access cycle
	assign o_done = o_psel && o_penable && i_pready;
	assign o_done_write = o_pwrite;
	assign o_rsp.data = i_prdata;
	assign o_rsp.err = i_pslverr;

endmodule

//--- axil2apb_consts.svh
`ifndef AXIL2APB_CONSTS_SVH
`define AXIL2APB_CONSTS_SVH

//////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////

// Byte address width on both buses
`define AXI_ADDR_W 32

// Data width on both buses
`define AXI_DATA_W 32

// One strobe bit per byte lane
`define AXI_STRB_W (`AXI_DATA_W / 8)

// Byte lane bits dropped from the address
`define AXI_LSB 2

// AxPROT and PPROT width
`define AXI_PROT_W 3

//////////////////////////////////////////////////
// Response codes
//////////////////////////////////////////////////
`define RESP_OKAY 2'b00
`define RESP_SLVERR 2'b10

`endif

//--- axil2apb_pkg.sv
`include "axil2apb_consts.svh"

package axil2apb_pkg;

	//////////////////////////////////////////////////
	// Request payloads
	//////////////////////////////////////////////////

	// Word address plus protection bits
	// Carried by the AW and AR skid buffers
	typedef struct packed
	{
		// Byte lane bits already removed
		logic [`AXI_ADDR_W-`AXI_LSB-1:0] addr;
		logic [`AXI_PROT_W-1:0] prot;
	} axil_addr_t;

	// Write data beat
	// Carried by the W skid buffer
	typedef struct packed
	{
		logic [`AXI_DATA_W-1:0] data;
		logic [`AXI_STRB_W-1:0] strb;
	} axil_wdata_t;

	//////////////////////////////////////////////////
	// Completion payload
	//////////////////////////////////////////////////

	// Sampled on the cycle PREADY completes
	typedef struct packed
	{
		// Meaningful for reads only
		logic [`AXI_DATA_W-1:0] data;
		// PSLVERR from the slave
		logic err;
	} apb_rsp_t;

endpackage

//--- axil2apb_top.sv
`timescale 1ns/10ps
`include "axil2apb_consts.svh"

// AXI-lite slave to APB master bridge
module axil2apb_top
(
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	// AXI-lite write address
	input logic i_s_axi_awvalid,
	output logic o_s_axi_awready,
	input logic [`AXI_ADDR_W-1:0] i_s_axi_awaddr,
	input logic [`AXI_PROT_W-1:0] i_s_axi_awprot,
	// AXI-lite write data
	input logic i_s_axi_wvalid,
	output logic o_s_axi_wready,
	input logic [`AXI_DATA_W-1:0] i_s_axi_wdata,
	input logic [`AXI_STRB_W-1:0] i_s_axi_wstrb,
	// AXI-lite write response
	output logic o_s_axi_bvalid,
	input logic i_s_axi_bready,
	output logic [1:0] o_s_axi_bresp,
	// AXI-lite read address
	input logic i_s_axi_arvalid,
	output logic o_s_axi_arready,
	input logic [`AXI_ADDR_W-1:0] i_s_axi_araddr,
	input logic [`AXI_PROT_W-1:0] i_s_axi_arprot,
	// AXI-lite read data
	output logic o_s_axi_rvalid,
	input logic i_s_axi_rready,
	output logic [`AXI_DATA_W-1:0] o_s_axi_rdata,
	output logic [1:0] o_s_axi_rresp,
	// APB master
	output logic o_m_apb_psel,
	output logic o_m_apb_penable,
	input logic i_m_apb_pready,
	output logic [`AXI_ADDR_W-1:0] o_m_apb_paddr,
	output logic o_m_apb_pwrite,
	output logic [`AXI_DATA_W-1:0] o_m_apb_pwdata,
	output logic [`AXI_STRB_W-1:0] o_m_apb_pwstrb,
	output logic [`AXI_PROT_W-1:0] o_m_apb_pprot,
	input logic [`AXI_DATA_W-1:0] i_m_apb_prdata,
	input logic i_m_apb_pslverr
);

	// Skid buffer outputs
	logic aw_valid, w_valid, ar_valid;
	axil2apb_pkg::axil_addr_t aw_pl, ar_pl;
	axil2apb_pkg::axil_wdata_t w_pl;

	// Control between stages
	logic wr_start, rd_start, done, done_write, b_stall, r_stall;
	axil2apb_pkg::apb_rsp_t rsp;

	//////////////////////////////////////////////////
	// Incoming channels
	//////////////////////////////////////////////////

	// Lane bits of the address are dropped here
	axil_skid_buffer #(.WIDTH($bits(axil2apb_pkg::axil_addr_t))) aw_skid (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_valid(i_s_axi_awvalid), .o_ready(o_s_axi_awready),
		.i_data({i_s_axi_awaddr[`AXI_ADDR_W-1:`AXI_LSB], i_s_axi_awprot}),
		.o_valid(aw_valid), .i_ready(wr_start), .o_data(aw_pl));
	axil_skid_buffer #(.WIDTH($bits(axil2apb_pkg::axil_wdata_t))) w_skid (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_valid(i_s_axi_wvalid), .o_ready(o_s_axi_wready),
		.i_data({i_s_axi_wdata, i_s_axi_wstrb}),
		.o_valid(w_valid), .i_ready(wr_start), .o_data(w_pl));
	axil_skid_buffer #(.WIDTH($bits(axil2apb_pkg::axil_addr_t))) ar_skid (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_valid(i_s_axi_arvalid), .o_ready(o_s_axi_arready),
		.i_data({i_s_axi_araddr[`AXI_ADDR_W-1:`AXI_LSB], i_s_axi_arprot}),
		.o_valid(ar_valid), .i_ready(rd_start), .o_data(ar_pl));

	//////////////////////////////////////////////////
	// Arbiter, APB phases, responses
	//////////////////////////////////////////////////

	// PSEL doubles as the busy flag
	rw_arbiter u_arbiter (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_aw_valid(aw_valid), .i_w_valid(w_valid), .i_ar_valid(ar_valid),
		.i_apb_busy(o_m_apb_psel), .i_b_stall(b_stall), .i_r_stall(r_stall),
		.o_wr_start(wr_start), .o_rd_start(rd_start));
	apb_sequencer u_sequencer (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_wr_start(wr_start), .i_rd_start(rd_start),
		.i_aw(aw_pl), .i_ar(ar_pl), .i_w(w_pl),
		.o_psel(o_m_apb_psel), .o_penable(o_m_apb_penable),
		.o_paddr(o_m_apb_paddr), .o_pwrite(o_m_apb_pwrite),
		.o_pwdata(o_m_apb_pwdata), .o_pwstrb(o_m_apb_pwstrb), .o_pprot(o_m_apb_pprot),
		.i_pready(i_m_apb_pready), .i_prdata(i_m_apb_prdata), .i_pslverr(i_m_apb_pslverr),
		.o_done(done), .o_done_write(done_write), .o_rsp(rsp));
	axil_response u_response (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_done(done), .i_done_write(done_write), .i_rsp(rsp),
		.o_bvalid(o_s_axi_bvalid), .i_bready(i_s_axi_bready), .o_bresp(o_s_axi_bresp),
		.o_rvalid(o_s_axi_rvalid), .i_rready(i_s_axi_rready),
		.o_rdata(o_s_axi_rdata), .o_rresp(o_s_axi_rresp),
		.o_b_stall(b_stall), .o_r_stall(r_stall));

endmodule

//--- axil_response.sv
`timescale 1ns/10ps
`include "axil2apb_consts.svh"

// AXI-lite B and R channel registers
// Loaded one cycle after an APB completion
module axil_response
(
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,

	// Completion from the sequencer
	input logic i_done,
	input logic i_done_write,
	input axil2apb_pkg::apb_rsp_t i_rsp,

	// Write response channel
	output logic o_bvalid,
	input logic i_bready,
	output logic [1:0] o_bresp,

	// Read data channel
	output logic o_rvalid,
	input logic i_rready,
	output logic [`AXI_DATA_W-1:0] o_rdata,
	output logic [1:0] o_rresp,

	// Back-pressure toward the arbiter
	output logic o_b_stall,
	output logic o_r_stall
);

	// Completion of each kind
	logic wr_done;
	logic rd_done;

	// Mapped response code
	logic [1:0] rsp_code;

	assign wr_done = i_done && i_done_write;
	assign rd_done = i_done && !i_done_write;
	assign rsp_code = i_rsp.err ? `RESP_SLVERR : `RESP_OKAY;

	//////////////////////////////////////////////////
	// Valid flags
	//////////////////////////////////////////////////

	// Held until accepted
	// Arbiter keeps completions away from a held response
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			o_bvalid <= 1'b0;
			o_rvalid <= 1'b0;
		end
		else
		begin
			if (wr_done)
				o_bvalid <= 1'b1;
			else if (i_bready)
				o_bvalid <= 1'b0;
			if (rd_done)
				o_rvalid <= 1'b1;
			else if (i_rready)
				o_rvalid <= 1'b0;
		end
	end

	// Response payloads
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (wr_done)
			o_bresp <= rsp_code;
		if (rd_done)
		begin
			o_rresp <= rsp_code;
			o_rdata <= i_rsp.data;
		end
	end

	assign o_b_stall = o_bvalid && !i_bready;
	assign o_r_stall = o_rvalid && !i_rready;

endmodule

//--- axil_skid_buffer.sv
`timescale 1ns/10ps

// Single entry valid/ready skid buffer
// Empty means a straight combinational path
module axil_skid_buffer
#(
	parameter int WIDTH = 32
)
(
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,

	// Upstream side
	input logic i_valid,
	output logic o_ready,
	input logic [WIDTH-1:0] i_data,

	// Downstream side
	output logic o_valid,
	input logic i_ready,
	output logic [WIDTH-1:0] o_data
);

	// Holding entry
	logic full;
	logic [WIDTH-1:0] hold_data;

	//////////////////////////////////////////////////
	// Occupancy
	//////////////////////////////////////////////////

	// Fill on an accepted beat the downstream refuses
	// Drain once the downstream takes the stored beat
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			full <= 1'b0;
		end
		else if (full)
		begin
			if (i_ready)
			begin
				full <= 1'b0;
			end
		end
		else if (i_valid && !i_ready)
		begin
			full <= 1'b1;
		end
	end

	// Capture only while empty
	// Full state keeps the older beat in place
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!full && i_valid && !i_ready)
		begin
			hold_data <= i_data;
		end
	end

	//////////////////////////////////////////////////
	// Outputs
	//////////////////////////////////////////////////

	// No new beat accepted while holding one
	assign o_ready = !full;

	// Stored beat goes out first to keep order
	assign o_valid = full || i_valid;
	assign o_data = full ? hold_data : i_data;

endmodule

//--- files.f
+incdir+.
axil2apb_pkg.sv
axil_skid_buffer.sv
rw_arbiter.sv
apb_sequencer.sv
axil_response.sv
axil2apb_top.sv
tb_axil2apb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wall -Wno-fatal \
	-f files.f --top-module tb_axil2apb -o sim_tb_axil2apb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_tb_axil2apb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation run returned status $status"
	exit 1
fi

if echo "$output" | grep -q "^Simulation completed successfully$"; then
	exit 0
fi
exit 1

//--- rw_arbiter.sv
`timescale 1ns/10ps

// Read/write arbiter in front of the APB sequencer
// Start strobes also pop the skid buffers
module rw_arbiter
(
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,

	// Skid buffer status
	input logic i_aw_valid,
	input logic i_w_valid,
	input logic i_ar_valid,

	// Downstream status
	input logic i_apb_busy,
	input logic i_b_stall,
	input logic i_r_stall,

	// One cycle start strobes
	output logic o_wr_start,
	output logic o_rd_start
);

	// High when a write wins a tie
	logic write_grant;

	// Requests that could go out this cycle
	logic wr_ok;
	logic rd_ok;

	//////////////////////////////////////////////////
	// Readiness
	//////////////////////////////////////////////////

	// Write needs both address and data
	// Held BVALID blocks another write
	assign wr_ok = i_aw_valid && i_w_valid && !i_apb_busy && !i_b_stall;

	// Held RVALID blocks another read
	assign rd_ok = i_ar_valid && !i_apb_busy && !i_r_stall;

	// Tie goes to the granted side
	// Otherwise the only ready side wins
	assign o_wr_start = wr_ok && (write_grant || !rd_ok);
	assign o_rd_start = rd_ok && (!write_grant || !wr_ok);

	//////////////////////////////////////////////////
	// Alternating grant
	//////////////////////////////////////////////////

	// Reads favoured out of reset
	// Flip toward the other side after each start
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			write_grant <= 1'b0;
		end
		else if (o_wr_start)
		begin
			write_grant <= 1'b0;
		end
		else if (o_rd_start)
		begin
			write_grant <= 1'b1;
		end
	end

endmodule

//--- tb_axil2apb.sv
`timescale 1ns/10ps

module tb_axil2apb;

	// Fixed pattern the APB slave model mixes into read data
	localparam logic [31:0] RD_KEY = 32'hc3a5_96e1;
	localparam int N_ENTRIES = 10;
	// Worst case per entry is two transfers, 5 waits, 5 hold-off cycles and driver overhead
	localparam int CYCLE_LIMIT = N_ENTRIES * 60 + 50;

	// Operation kinds
	localparam logic [2:0] OP_WR = 3'd0;
	localparam logic [2:0] OP_RD = 3'd1;
	localparam logic [2:0] OP_BOTH = 3'd2;
	localparam logic [2:0] OP_WR_PAIR = 3'd3;
	localparam logic [2:0] OP_RD_PAIR = 3'd4;

	typedef struct packed
	{
		logic [2:0] op;
		logic [31:0] addr;
		logic [2:0] prot;
		logic [31:0] wdata;
		logic [3:0] wstrb;
		logic err;
		// 4'hf picks a random count
		logic [3:0] waits;
		logic [3:0] holdoff;
	} stim_t;

	logic S_AXI_ACLK, S_AXI_ARESETN;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [31:0] awaddr, araddr, wdata, rdata, paddr, pwdata, prdata;
	logic [2:0] awprot, arprot, pprot;
	logic [3:0] wstrb, pwstrb;
	logic [1:0] bresp, rresp;
	logic psel, penable, pready, pwrite, pslverr;

	stim_t tbl [0:N_ENTRIES-1];
	int errors = 0;
	int cycles = 0;
	int cur_waits = 0;
	logic cur_err = 1'b0;
	int wr_cnt = 0;
	int rd_cnt = 0;
	logic grant_wr = 1'b0;

	// Transfers seen by the APB slave model
	logic q_write [$];
	logic [31:0] q_addr [$];
	logic [2:0] q_prot [$];
	logic [31:0] q_wdata [$];
	logic [3:0] q_wstrb [$];

	axil2apb_top uut (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_s_axi_awvalid(awvalid), .o_s_axi_awready(awready),
		.i_s_axi_awaddr(awaddr), .i_s_axi_awprot(awprot),
		.i_s_axi_wvalid(wvalid), .o_s_axi_wready(wready),
		.i_s_axi_wdata(wdata), .i_s_axi_wstrb(wstrb),
		.o_s_axi_bvalid(bvalid), .i_s_axi_bready(bready), .o_s_axi_bresp(bresp),
		.i_s_axi_arvalid(arvalid), .o_s_axi_arready(arready),
		.i_s_axi_araddr(araddr), .i_s_axi_arprot(arprot),
		.o_s_axi_rvalid(rvalid), .i_s_axi_rready(rready),
		.o_s_axi_rdata(rdata), .o_s_axi_rresp(rresp),
		.o_m_apb_psel(psel), .o_m_apb_penable(penable), .i_m_apb_pready(pready),
		.o_m_apb_paddr(paddr), .o_m_apb_pwrite(pwrite), .o_m_apb_pwdata(pwdata),
		.o_m_apb_pwstrb(pwstrb), .o_m_apb_pprot(pprot),
		.i_m_apb_prdata(prdata), .i_m_apb_pslverr(pslverr));

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #5 S_AXI_ACLK = !S_AXI_ACLK;
	end

	// Run limit
	always @(posedge S_AXI_ACLK)
	begin
		cycles <= cycles + 1;
		if (cycles > CYCLE_LIMIT)
		begin
			$display("Timeout: the bridge stopped responding after %0d cycles", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	//////////////////////////////////////////////////
	// APB slave model
	//////////////////////////////////////////////////

	// Setup seen at the falling edge and replies driven 1 ns after the rising edge
	initial
	begin
		logic [31:0] s_addr, s_wdata;
		logic [2:0] s_prot;
		logic [3:0] s_strb;
		logic s_write, fin;
		int n;
		forever
		begin
			@(negedge S_AXI_ACLK);
			if (psel && !penable)
			begin
				s_addr = paddr;
				s_write = pwrite;
				s_prot = pprot;
				s_wdata = pwdata;
				s_strb = pwstrb;
				q_write.push_back(s_write);
				q_addr.push_back(s_addr);
				q_prot.push_back(s_prot);
				q_wdata.push_back(s_wdata);
				q_wstrb.push_back(s_strb);
				if (s_write)
					wr_cnt++;
				else
					rd_cnt++;
				n = 0;
				fin = 1'b0;
				@(posedge S_AXI_ACLK);
				#1;
				pready = (cur_waits == 0);
				pslverr = cur_err && pready;
				prdata = s_addr ^ RD_KEY;
				while (!fin)
				begin
					@(negedge S_AXI_ACLK);
					compare("PSEL", psel, 1);
					compare("PENABLE", penable, 1);
					compare("PADDR", paddr, s_addr);
					compare("PWRITE", pwrite, s_write);
					compare("PPROT", pprot, s_prot);
					if (s_write)
					begin
						compare("PWDATA", pwdata, s_wdata);
						compare("PWSTRB", pwstrb, s_strb);
					end
					fin = pready;
					@(posedge S_AXI_ACLK);
					#1;
					n++;
					pready = !fin && (n >= cur_waits);
					pslverr = cur_err && pready;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// AXI-lite master side
	//////////////////////////////////////////////////

	task automatic send_write(input logic [31:0] a, input logic [2:0] p,
		input logic [31:0] d, input logic [3:0] s);
		logic aw_done, w_done, aw_hs, w_hs;
		aw_done = 1'b0;
		w_done = 1'b0;
		@(posedge S_AXI_ACLK);
		#1;
		awvalid = 1'b1;
		awaddr = a;
		awprot = p;
		wvalid = 1'b1;
		wdata = d;
		wstrb = s;
		while (!(aw_done && w_done))
		begin
			@(negedge S_AXI_ACLK);
			aw_hs = awvalid && awready;
			w_hs = wvalid && wready;
			@(posedge S_AXI_ACLK);
			#1;
			if (aw_hs)
			begin
				awvalid = 1'b0;
				aw_done = 1'b1;
			end
			if (w_hs)
			begin
				wvalid = 1'b0;
				w_done = 1'b1;
			end
		end
	endtask

	task automatic send_read(input logic [31:0] a, input logic [2:0] p);
		logic hs;
		hs = 1'b0;
		@(posedge S_AXI_ACLK);
		#1;
		arvalid = 1'b1;
		araddr = a;
		arprot = p;
		while (!hs)
		begin
			@(negedge S_AXI_ACLK);
			hs = arready;
			@(posedge S_AXI_ACLK);
			#1;
			if (hs)
				arvalid = 1'b0;
		end
	endtask

	// Holds the response for some cycles, then accepts it
	task automatic take_response(input logic is_wr, input int holdoff,
		input logic [1:0] exp_resp, input logic [31:0] exp_data);
		logic [1:0] h_resp;
		logic [31:0] h_data;
		int h_cnt;
		@(negedge S_AXI_ACLK);
		while (is_wr ? !bvalid : !rvalid)
			@(negedge S_AXI_ACLK);
		h_resp = is_wr ? bresp : rresp;
		h_data = rdata;
		h_cnt = is_wr ? wr_cnt : rd_cnt;
		compare(is_wr ? "BRESP" : "RRESP", h_resp, exp_resp);
		if (!is_wr)
			compare("RDATA", h_data, exp_data);
		for (int i = 0; i < holdoff; i++)
		begin
			@(negedge S_AXI_ACLK);
			compare(is_wr ? "BVALID" : "RVALID", is_wr ? bvalid : rvalid, 1);
			compare(is_wr ? "BRESP" : "RRESP", is_wr ? bresp : rresp, h_resp);
			if (!is_wr)
				compare("RDATA", rdata, h_data);
			compare("APB transfer count", is_wr ? wr_cnt : rd_cnt, h_cnt);
		end
		@(posedge S_AXI_ACLK);
		#1;
		if (is_wr)
			bready = 1'b1;
		else
			rready = 1'b1;
		@(posedge S_AXI_ACLK);
		#1;
		bready = is_wr ? 1'b0 : bready;
		rready = is_wr ? rready : 1'b0;
	endtask

	// Pops the next APB transfer and checks it against the expected request
	task automatic check_apb(input logic is_wr, input logic [31:0] a, input logic [2:0] p,
		input logic [31:0] d, input logic [3:0] s);
		if (q_write.size() == 0)
		begin
			errors++;
			$display("Expected an APB transfer at %0t but none was seen", $time);
		end
		else
		begin
			compare("PWRITE order", q_write.pop_front(), is_wr);
			compare("PADDR", q_addr.pop_front(), {a[31:2], 2'b00});
			compare("PPROT", q_prot.pop_front(), p);
			// Write data lanes carry nothing on a read
			if (is_wr)
			begin
				compare("PWDATA", q_wdata.pop_front(), d);
				compare("PWSTRB", q_wstrb.pop_front(), s);
			end
			else
			begin
				void'(q_wdata.pop_front());
				void'(q_wstrb.pop_front());
			end
		end
		// Tie break flips toward the other kind
		grant_wr = !is_wr;
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial
	begin
		stim_t e;
		logic [31:0] ra;
		logic [31:0] na;
		logic [1:0] er;
		logic wr_first;
		void'($urandom(32'hee23_f155));
		S_AXI_ARESETN = 1'b0;
		{awvalid, wvalid, arvalid, bready, rready, pready, pslverr} = '0;
		{awaddr, araddr, wdata, prdata} = '0;
		{awprot, arprot, wstrb} = '0;
		// op, addr, prot, wdata, wstrb, err, waits, holdoff
		tbl[0] = {OP_BOTH, 32'h1000_0013, 3'd1, 32'h1111_2222, 4'hf, 1'b0, 4'd0, 4'd0};
		tbl[1] = {OP_WR, 32'h0000_0107, 3'd2, 32'hdead_beef, 4'h6, 1'b0, 4'd0, 4'd0};
		tbl[2] = {OP_RD, 32'h0000_0202, 3'd5, 32'h0, 4'h0, 1'b0, 4'hf, 4'd0};
		tbl[3] = {OP_WR, 32'h0000_0340, 3'd0, 32'h0bad_f00d, 4'h3, 1'b1, 4'd2, 4'd0};
		tbl[4] = {OP_RD, 32'h0000_0481, 3'd7, 32'h0, 4'h0, 1'b1, 4'd1, 4'd0};
		tbl[5] = {OP_BOTH, 32'h2000_0041, 3'd3, 32'h5555_aaaa, 4'h9, 1'b0, 4'd0, 4'd0};
		tbl[6] = {OP_BOTH, 32'h3000_0ff2, 3'd4, 32'h0123_4567, 4'hc, 1'b0, 4'd1, 4'd0};
		tbl[7] = {OP_WR_PAIR, 32'h4000_0103, 3'd6, 32'h89ab_cdef, 4'h1, 1'b0, 4'd0, 4'd5};
		tbl[8] = {OP_RD_PAIR, 32'h5000_0006, 3'd2, 32'h0, 4'h0, 1'b0, 4'hf, 4'd4};
		tbl[9] = {OP_WR, 32'h6000_0019, 3'd1, 32'hfeed_0001, 4'hf, 1'b0, 4'hf, 4'd3};
		repeat (2) @(posedge S_AXI_ACLK);
		#1;
		S_AXI_ARESETN = 1'b1;
		@(negedge S_AXI_ACLK);
		compare("PSEL", psel, 0);
		compare("PENABLE", penable, 0);
		compare("BVALID", bvalid, 0);
		compare("RVALID", rvalid, 0);
		compare("AWREADY", awready, 1);
		compare("WREADY", wready, 1);
		compare("ARREADY", arready, 1);
		for (int i = 0; i < N_ENTRIES; i++)
		begin
			e = tbl[i];
			cur_waits = (e.waits == 4'hf) ? int'($urandom_range(0, 5)) : int'(e.waits);
			cur_err = e.err;
			er = e.err ? 2'b10 : 2'b00;
			ra = e.addr ^ 32'h0000_0100;
			na = e.addr + 32'd4;
			case (e.op)
				OP_WR:
				begin
					send_write(e.addr, e.prot, e.wdata, e.wstrb);
					take_response(1'b1, e.holdoff, er, 32'h0);
					check_apb(1'b1, e.addr, e.prot, e.wdata, e.wstrb);
				end
				OP_RD:
				begin
					send_read(e.addr, e.prot);
					take_response(1'b0, e.holdoff, er, {e.addr[31:2], 2'b00} ^ RD_KEY);
					check_apb(1'b0, e.addr, e.prot, 32'h0, 4'h0);
				end
				OP_BOTH:
				begin
					wr_first = grant_wr;
					fork
						send_write(e.addr, e.prot, e.wdata, e.wstrb);
						send_read(ra, e.prot);
					join
					fork
						take_response(1'b1, 0, er, 32'h0);
						take_response(1'b0, 0, er, {ra[31:2], 2'b00} ^ RD_KEY);
					join
					if (wr_first)
					begin
						check_apb(1'b1, e.addr, e.prot, e.wdata, e.wstrb);
						check_apb(1'b0, ra, e.prot, 32'h0, 4'h0);
					end
					else
					begin
						check_apb(1'b0, ra, e.prot, 32'h0, 4'h0);
						check_apb(1'b1, e.addr, e.prot, e.wdata, e.wstrb);
					end
				end
				OP_WR_PAIR:
				begin
					// Second write waits in the skid buffers behind a held BVALID
					send_write(e.addr, e.prot, e.wdata, e.wstrb);
					send_write(na, e.prot, ~e.wdata, e.wstrb);
					@(negedge S_AXI_ACLK);
					compare("AWREADY", awready, 0);
					compare("WREADY", wready, 0);
					take_response(1'b1, e.holdoff, er, 32'h0);
					take_response(1'b1, 0, er, 32'h0);
					check_apb(1'b1, e.addr, e.prot, e.wdata, e.wstrb);
					check_apb(1'b1, na, e.prot, ~e.wdata, e.wstrb);
				end
				default:
				begin
					// Read pair, second read waits behind a held RVALID
					send_read(e.addr, e.prot);
					send_read(na, e.prot);
					@(negedge S_AXI_ACLK);
					compare("ARREADY", arready, 0);
					take_response(1'b0, e.holdoff, er, {e.addr[31:2], 2'b00} ^ RD_KEY);
					take_response(1'b0, 0, er, {na[31:2], 2'b00} ^ RD_KEY);
					check_apb(1'b0, e.addr, e.prot, 32'h0, 4'h0);
					check_apb(1'b0, na, e.prot, 32'h0, 4'h0);
				end
			endcase
		end
		if (q_write.size() != 0)
		begin
			errors++;
			$display("The APB slave saw %0d unexpected extra transfers", q_write.size());
		end
		$display("Entries: %0d, errors: %0d", N_ENTRIES, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
